// ==== arp_config.svh ====
// Build-time constants for the ARP subsystem
// Included by any file that needs the cache size or the fixed header values
// Change ARP_CACHE_ADDR_WIDTH to resize the cache (entries = 2 ** width)

`ifndef ARP_CONFIG_SVH
`define ARP_CONFIG_SVH

// Log2 of the number of cache entries
`define ARP_CACHE_ADDR_WIDTH 2

// Fixed header values for Ethernet hardware over IPv4
`define ARP_HTYPE_ETH  16'h0001
`define ARP_PTYPE_IPV4 16'h0800

// Address lengths in bytes
`define ARP_HLEN 8'd6
`define ARP_PLEN 8'd4

`endif

// ==== arp_pkg.sv ====
// Frame-level types for the ARP subsystem
// Holds the parsed header layout, the opcode values and the command
// that decode hands to the reply stage
// Refer to items by scoped name, e.g. arp_pkg::arp_hdr_t

package arp_pkg;

    // ARP operation codes as carried on the wire
    typedef enum logic [15:0] {
        ARP_OPER_REQUEST = 16'd1,
        ARP_OPER_REPLY   = 16'd2
    } arp_oper_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Parsed 28-byte header, first wire byte in the top bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [15:0] htype;
        logic [15:0] ptype;
        logic [7:0]  hlen;
        logic [7:0]  plen;
        // Kept as raw bits so malformed opcodes can be carried
        logic [15:0] oper;
        // Sender hardware and protocol address
        logic [47:0] sha;
        logic [31:0] spa;
        // Target hardware and protocol address
        logic [47:0] tha;
        logic [31:0] tpa;
    } arp_hdr_t;

    // Requester addresses for a reply to be built
    typedef struct packed {
        logic [47:0] req_mac;
        logic [31:0] req_ip;
    } reply_cmd_t;

endpackage

// ==== cache_pkg.sv ====
// Types shared across the ARP cache boundary
// Covers the learning write, the lookup result and the entry index
// Refer to items by scoped name, e.g. cache_pkg::cache_resp_t

`include "arp_config.svh"

package cache_pkg;

    // Table size derived from the config header
    localparam int CACHE_ENTRIES = 2 ** `ARP_CACHE_ADDR_WIDTH;

    // Index into the table
    typedef logic [`ARP_CACHE_ADDR_WIDTH-1:0] cache_idx_t;

    // One learned IP to MAC pair
    typedef struct packed {
        logic [31:0] ip;
        logic [47:0] mac;
    } cache_write_t;

    // Lookup result
    typedef struct packed {
        // Set on a miss
        logic        error;
        // Valid only when error is clear
        logic [47:0] mac;
    } cache_resp_t;

endpackage

// ==== arp_decode.sv ====
// Decode stage of the ARP subsystem
// Checks the fixed fields of an incoming header, forwards the sender pair
// to the cache as a learning write and issues a reply command for requests
// aimed at the local IP. Both outputs appear one cycle after the frame strobe
// Malformed frames and frames that meet a busy cache are counted

`include "arp_config.svh"

module arp_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frame_valid,
    input  arp_pkg::arp_hdr_t       frame,
    input  logic [31:0]             local_ip,
    input  logic                    busy,
    output logic                    write_valid,
    output cache_pkg::cache_write_t write_req,
    output logic                    reply_cmd_valid,
    output arp_pkg::reply_cmd_t     reply_cmd,
    output logic [15:0]             drop_count
);

    logic well_formed;
    logic oper_ok;
    logic for_us;
    logic cache_blocked;
    logic learn;
    logic drop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Header checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Only request and reply are legal opcodes
    assign oper_ok = (frame.oper == arp_pkg::ARP_OPER_REQUEST) ||
                     (frame.oper == arp_pkg::ARP_OPER_REPLY);

    assign well_formed = (frame.htype == `ARP_HTYPE_ETH) &&
                         (frame.ptype == `ARP_PTYPE_IPV4) &&
                         (frame.hlen == `ARP_HLEN) &&
                         (frame.plen == `ARP_PLEN) && oper_ok;

    // Request asking for our MAC
    assign for_us = (frame.oper == arp_pkg::ARP_OPER_REQUEST) && (frame.tpa == local_ip);

    // A write issued on the last edge has not raised busy yet
    assign cache_blocked = busy || write_valid;

    assign learn = frame_valid && well_formed && !cache_blocked;
    assign drop  = frame_valid && (!well_formed || cache_blocked);

    // Strobes and drop counter
    always_ff @(posedge clk) begin
        if (rst) begin
            write_valid     <= 1'b0;
            reply_cmd_valid <= 1'b0;
            drop_count      <= '0;
        end else begin
            write_valid     <= learn;
            // Reply goes out even when the learn write is dropped
            reply_cmd_valid <= frame_valid && well_formed && for_us;
            // Saturate at all ones
            if (drop && !(&drop_count)) begin
                drop_count <= drop_count + 16'd1;
            end
        end
    end

    // Payload registers, loaded only with their strobe
    always_ff @(posedge clk) begin
        if (learn) begin
            write_req.ip  <= frame.spa;
            write_req.mac <= frame.sha;
        end
        if (frame_valid) begin
            reply_cmd.req_mac <= frame.sha;
            reply_cmd.req_ip  <= frame.spa;
        end
    end

endmodule

// ==== arp_cache.sv ====
// Execute stage of the ARP subsystem
// Small fully associative IP to MAC table with one used bit per entry
// Lookups answer one cycle after the query strobe and run beside writes
// A learning write first searches for its IP one entry per cycle, then
// falls back to round-robin replacement of an entry whose used bit is clear
// Reset and a rising clear_cache run a sweep that invalidates every entry

module arp_cache (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    query_valid,
    input  logic [31:0]             query_ip,
    input  logic                    write_valid,
    input  cache_pkg::cache_write_t write_req,
    input  logic                    clear_cache,
    output logic                    query_resp_valid,
    output cache_pkg::cache_resp_t  query_resp,
    output logic                    busy,
    output logic                    learn_done
);

    localparam int ENTRIES = cache_pkg::CACHE_ENTRIES;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEARCH,
        ST_REPLACE,
        ST_CLEAR
    } state_e;

    // Table storage
    logic [31:0]        ip_mem  [ENTRIES];
    logic [47:0]        mac_mem [ENTRIES];
    logic [ENTRIES-1:0] valid;
    logic [ENTRIES-1:0] used;

    state_e                  state;
    // Shared by the search and the clear sweep
    cache_pkg::cache_idx_t   idx;
    cache_pkg::cache_idx_t   rr_ptr;
    cache_pkg::cache_write_t wr_q;

    logic                  clear_q;
    logic                  clear_pend;
    logic                  clear_rise;
    logic                  hit;
    cache_pkg::cache_idx_t hit_idx;
    logic                  idx_match;

    assign clear_rise = clear_cache && !clear_q;
    assign busy       = (state != ST_IDLE);

    // Search compares one entry per cycle against the held write
    assign idx_match = valid[idx] && (ip_mem[idx] == wr_q.ip);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Parallel lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (valid[i] && (ip_mem[i] == query_ip)) begin
                hit     = 1'b1;
                hit_idx = cache_pkg::cache_idx_t'(i);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control FSM and used bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            // Reset starts with a full sweep
            state            <= ST_CLEAR;
            idx              <= '0;
            rr_ptr           <= '0;
            used             <= '0;
            clear_q          <= 1'b0;
            clear_pend       <= 1'b0;
            learn_done       <= 1'b0;
            query_resp_valid <= 1'b0;
        end else begin
            learn_done       <= 1'b0;
            query_resp_valid <= query_valid;
            clear_q          <= clear_cache;

            // Remember a clear that cannot start this cycle
            if (clear_rise && state != ST_CLEAR) begin
                clear_pend <= 1'b1;
            end

            // All entries recently used, so age them all at once
            if (&used) begin
                used <= '0;
            end
            if (query_valid && hit) begin
                used[hit_idx] <= 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    idx <= '0;
                    // A write beats a clear arriving on the same edge
                    if (write_valid) begin
                        state <= ST_SEARCH;
                    end else if (clear_rise || clear_pend) begin
                        state      <= ST_CLEAR;
                        clear_pend <= 1'b0;
                    end
                end
                ST_SEARCH: begin
                    idx <= idx + 1'b1;
                    if (idx_match) begin
                        state      <= ST_IDLE;
                        learn_done <= 1'b1;
                    end else if (&idx) begin
                        state <= ST_REPLACE;
                    end
                end
                ST_REPLACE: begin
                    // Pointer holds while the used bits are being aged
                    if (!used[rr_ptr]) begin
                        rr_ptr     <= rr_ptr + 1'b1;
                        state      <= ST_IDLE;
                        learn_done <= 1'b1;
                    end else if (!(&used)) begin
                        rr_ptr <= rr_ptr + 1'b1;
                    end
                end
                ST_CLEAR: begin
                    used[idx] <= 1'b0;
                    idx       <= idx + 1'b1;
                    if (&idx) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Table writes and response payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && write_valid) begin
            wr_q <= write_req;
        end

        if (state == ST_CLEAR) begin
            valid[idx] <= 1'b0;
        end else if (state == ST_SEARCH && idx_match) begin
            // Known IP, refresh its MAC in place
            mac_mem[idx] <= wr_q.mac;
        end else if (state == ST_REPLACE && !used[rr_ptr]) begin
            ip_mem[rr_ptr]  <= wr_q.ip;
            mac_mem[rr_ptr] <= wr_q.mac;
            valid[rr_ptr]   <= 1'b1;
        end

        if (query_valid) begin
            query_resp.error <= !hit;
            query_resp.mac   <= hit ? mac_mem[hit_idx] : 48'd0;
        end
    end

endmodule

// ==== arp_reply.sv ====
// Result stage of the ARP subsystem
// Turns a reply command from decode into a full reply header
// The local addresses become the sender and the requester the target
// reply_valid follows reply_cmd_valid by one cycle

`include "arp_config.svh"

module arp_reply (
    input  logic                clk,
    input  logic                rst,
    input  logic                reply_cmd_valid,
    input  arp_pkg::reply_cmd_t reply_cmd,
    input  logic [47:0]         local_mac,
    input  logic [31:0]         local_ip,
    output logic                reply_valid,
    output arp_pkg::arp_hdr_t   reply_frame
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output strobe
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            reply_valid <= 1'b0;
        end else begin
            reply_valid <= reply_cmd_valid;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Header build
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Loaded only with a command, held otherwise
    always_ff @(posedge clk) begin
        if (reply_cmd_valid) begin
            // Fixed type and length fields
            reply_frame.htype <= `ARP_HTYPE_ETH;
            reply_frame.ptype <= `ARP_PTYPE_IPV4;
            reply_frame.hlen  <= `ARP_HLEN;
            reply_frame.plen  <= `ARP_PLEN;
            reply_frame.oper  <= arp_pkg::ARP_OPER_REPLY;

            // We answer as the sender
            reply_frame.sha <= local_mac;
            reply_frame.spa <= local_ip;

            // Requester becomes the target
            reply_frame.tha <= reply_cmd.req_mac;
            reply_frame.tpa <= reply_cmd.req_ip;
        end
    end

endmodule

// ==== arp_top.sv ====
// Top level of the ARP learning and answering subsystem
// Chains decode, cache and reply stages. Frames enter as parsed headers,
// replies leave two cycles later. The cache also serves IP lookups
// local_mac and local_ip are static configuration inputs

module arp_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   frame_valid,
    input  arp_pkg::arp_hdr_t      frame,
    input  logic                   query_valid,
    input  logic [31:0]            query_ip,
    input  logic                   clear_cache,
    input  logic [47:0]            local_mac,
    input  logic [31:0]            local_ip,
    output logic                   query_resp_valid,
    output cache_pkg::cache_resp_t query_resp,
    output logic                   reply_valid,
    output arp_pkg::arp_hdr_t      reply_frame,
    output logic                   learn_done,
    output logic                   cache_busy,
    output logic [15:0]            drop_count
);

    // Decode to cache
    logic                    write_valid;
    cache_pkg::cache_write_t write_req;

    // Decode to reply
    logic                    reply_cmd_valid;
    arp_pkg::reply_cmd_t     reply_cmd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    arp_decode u_decode (
        .clk             (clk),
        .rst             (rst),
        .frame_valid     (frame_valid),
        .frame           (frame),
        .local_ip        (local_ip),
        .busy            (cache_busy),
        .write_valid     (write_valid),
        .write_req       (write_req),
        .reply_cmd_valid (reply_cmd_valid),
        .reply_cmd       (reply_cmd),
        .drop_count      (drop_count)
    );

    arp_cache u_cache (
        .clk              (clk),
        .rst              (rst),
        .query_valid      (query_valid),
        .query_ip         (query_ip),
        .write_valid      (write_valid),
        .write_req        (write_req),
        .clear_cache      (clear_cache),
        .query_resp_valid (query_resp_valid),
        .query_resp       (query_resp),
        .busy             (cache_busy),
        .learn_done       (learn_done)
    );

    arp_reply u_reply (
        .clk             (clk),
        .rst             (rst),
        .reply_cmd_valid (reply_cmd_valid),
        .reply_cmd       (reply_cmd),
        .local_mac       (local_mac),
        .local_ip        (local_ip),
        .reply_valid     (reply_valid),
        .reply_frame     (reply_frame)
    );

endmodule

// ==== tb_arp_top.sv ====
// Self-checking testbench for the ARP subsystem top level
// Builds a table of frames, queries, clears and idle gaps, then applies it
// in a loop. Frame entries carry the expected learn, reply and drop outcome
// A behavioral model of the cache predicts every lookup result
// Stops at the first mismatch. A watchdog bounds the whole run

`include "arp_config.svh"

module tb_arp_top;

    localparam int ENTRIES  = 1 << `ARP_CACHE_ADDR_WIDTH;
    // Longest wait for any single handshake, in cycles
    localparam int WAIT_MAX = 4 * ENTRIES + 16;

    typedef enum logic [1:0] {
        STEP_FRAME,
        STEP_QUERY,
        STEP_CLEAR,
        STEP_GAP
    } step_kind_e;

    // One table entry with its stimulus and expected outcome
    typedef struct packed {
        step_kind_e        kind;
        arp_pkg::arp_hdr_t hdr;
        logic [31:0]       ip;
        logic              exp_learn;
        logic              exp_reply;
        logic              exp_drop;
        // Next entry starts without waiting for the cache
        logic              no_wait;
        logic [7:0]        cycles;
    } step_t;

    logic                   clk;
    logic                   rst;
    logic                   frame_valid;
    arp_pkg::arp_hdr_t      frame;
    logic                   query_valid;
    logic [31:0]            query_ip;
    logic                   clear_cache;
    logic [47:0]            local_mac;
    logic [31:0]            local_ip;
    logic                   query_resp_valid;
    cache_pkg::cache_resp_t query_resp;
    logic                   reply_valid;
    arp_pkg::arp_hdr_t      reply_frame;
    logic                   learn_done;
    logic                   cache_busy;
    logic [15:0]            drop_count;

    step_t       steps[$];
    logic [31:0] lcg_state;
    logic [31:0] ip_pool  [8];
    logic [47:0] mac_pool [10];
    int          timeout_cycles;

    // Cache model state
    logic [31:0] m_ip    [ENTRIES];
    logic [47:0] m_mac   [ENTRIES];
    logic        m_valid [ENTRIES];
    logic        m_used  [ENTRIES];
    int          m_ptr;

    arp_top uut (
        .clk              (clk),
        .rst              (rst),
        .frame_valid      (frame_valid),
        .frame            (frame),
        .query_valid      (query_valid),
        .query_ip         (query_ip),
        .clear_cache      (clear_cache),
        .local_mac        (local_mac),
        .local_ip         (local_ip),
        .query_resp_valid (query_resp_valid),
        .query_resp       (query_resp),
        .reply_valid      (reply_valid),
        .reply_frame      (reply_frame),
        .learn_done       (learn_done),
        .cache_busy       (cache_busy),
        .drop_count       (drop_count)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting and random values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input logic [223:0] expected,
            input logic [223:0] actual);
        if (expected !== actual) begin
            stop_on_failure($sformatf("** Error: %s expected 0x%0h got 0x%0h",
                                      name, expected, actual));
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [47:0] rand_mac();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[15:0], lo};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cache model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic int model_find(input logic [31:0] ip);
        for (int i = 0; i < ENTRIES; i++) begin
            if (m_valid[i] && m_ip[i] == ip) begin
                return i;
            end
        end
        return -1;
    endfunction

    // A query hit marks the entry and a full set of marks ages every entry
    function automatic void model_touch(input int idx);
        logic all_used;
        m_used[idx] = 1'b1;
        all_used = 1'b1;
        for (int i = 0; i < ENTRIES; i++) begin
            all_used = all_used & m_used[i];
        end
        if (all_used) begin
            for (int i = 0; i < ENTRIES; i++) begin
                m_used[i] = 1'b0;
            end
        end
    endfunction

    function automatic void model_learn(input logic [31:0] ip, input logic [47:0] mac);
        int idx;
        idx = model_find(ip);
        if (idx < 0) begin
            // First entry at or after the pointer whose used bit is clear
            idx = m_ptr;
            for (int k = 0; k < ENTRIES && m_used[idx]; k++) begin
                idx = (idx + 1) % ENTRIES;
            end
            m_ip[idx]    = ip;
            m_valid[idx] = 1'b1;
            m_ptr        = (idx + 1) % ENTRIES;
        end
        m_mac[idx] = mac;
    endfunction

    function automatic void model_clear();
        for (int i = 0; i < ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_used[i]  = 1'b0;
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame building and table entries
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic arp_pkg::arp_hdr_t make_frame(input logic [15:0] oper,
            input logic [47:0] sha, input logic [31:0] spa, input logic [31:0] tpa);
        arp_pkg::arp_hdr_t h;
        h.htype = `ARP_HTYPE_ETH;
        h.ptype = `ARP_PTYPE_IPV4;
        h.hlen  = `ARP_HLEN;
        h.plen  = `ARP_PLEN;
        h.oper  = oper;
        h.sha   = sha;
        h.spa   = spa;
        h.tha   = '0;
        h.tpa   = tpa;
        return h;
    endfunction

    // Reply carries the local addresses as sender and the requester as target
    function automatic arp_pkg::arp_hdr_t expected_reply(input arp_pkg::arp_hdr_t req);
        arp_pkg::arp_hdr_t h;
        h     = make_frame(arp_pkg::ARP_OPER_REPLY, local_mac, local_ip, req.spa);
        h.tha = req.sha;
        return h;
    endfunction

    function automatic void add_frame(input arp_pkg::arp_hdr_t hdr, input logic learn,
            input logic reply, input logic drop, input logic no_wait);
        step_t s;
        s           = '0;
        s.kind      = STEP_FRAME;
        s.hdr       = hdr;
        s.exp_learn = learn;
        s.exp_reply = reply;
        s.exp_drop  = drop;
        s.no_wait   = no_wait;
        steps.push_back(s);
    endfunction

    function automatic void add_query(input logic [31:0] ip);
        step_t s;
        s      = '0;
        s.kind = STEP_QUERY;
        s.ip   = ip;
        steps.push_back(s);
    endfunction

    function automatic void add_clear(input logic no_wait);
        step_t s;
        s         = '0;
        s.kind    = STEP_CLEAR;
        s.no_wait = no_wait;
        steps.push_back(s);
    endfunction

    function automatic void add_gap(input logic [7:0] cycles);
        step_t s;
        s        = '0;
        s.kind   = STEP_GAP;
        s.cycles = cycles;
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        arp_pkg::arp_hdr_t h;
        // Learn, reply to local requests, hit and miss lookups
        add_frame(make_frame(arp_pkg::ARP_OPER_REQUEST, mac_pool[0], ip_pool[0], local_ip),
                  1'b1, 1'b1, 1'b0, 1'b0);
        add_query(ip_pool[0]);
        add_query(ip_pool[7]);
        add_frame(make_frame(arp_pkg::ARP_OPER_REQUEST, mac_pool[1], ip_pool[1], ip_pool[6]),
                  1'b1, 1'b0, 1'b0, 1'b0);
        add_frame(make_frame(arp_pkg::ARP_OPER_REPLY, mac_pool[2], ip_pool[2], local_ip),
                  1'b1, 1'b0, 1'b0, 1'b0);
        add_query(ip_pool[1]);
        // Relearn ip 0 with a new MAC
        add_frame(make_frame(arp_pkg::ARP_OPER_REQUEST, mac_pool[3], ip_pool[0], local_ip),
                  1'b1, 1'b1, 1'b0, 1'b0);
        add_query(ip_pool[0]);
        add_query(ip_pool[1]);
        add_query(ip_pool[2]);
        // Overflow the table with used bits set in between
        add_frame(make_frame(arp_pkg::ARP_OPER_REQUEST, mac_pool[4], ip_pool[3], ip_pool[6]),
                  1'b1, 1'b0, 1'b0, 1'b0);
        add_query(ip_pool[3]);
        add_frame(make_frame(arp_pkg::ARP_OPER_REQUEST, mac_pool[5], ip_pool[4], ip_pool[6]),
                  1'b1, 1'b0, 1'b0, 1'b0);
        add_query(ip_pool[1]);
        add_frame(make_frame(arp_pkg::ARP_OPER_REPLY, mac_pool[6], ip_pool[5], ip_pool[6]),
                  1'b1, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 6; i++) begin
            add_query(ip_pool[i]);
        end
        // Malformed frames
        h      = make_frame(arp_pkg::ARP_OPER_REQUEST, mac_pool[7], ip_pool[6], local_ip);
        h.hlen = 8'd5;
        add_frame(h, 1'b0, 1'b0, 1'b1, 1'b0);
        add_frame(make_frame(16'd3, mac_pool[7], ip_pool[6], local_ip), 1'b0, 1'b0, 1'b1, 1'b0);
        h       = make_frame(arp_pkg::ARP_OPER_REQUEST, mac_pool[7], ip_pool[6], local_ip);
        h.ptype = 16'h86dd;
        add_frame(h, 1'b0, 1'b0, 1'b1, 1'b0);
        add_query(ip_pool[6]);
        // Second frame lands while the first is still searching
        add_frame(make_frame(arp_pkg::ARP_OPER_REQUEST, mac_pool[8], ip_pool[6], ip_pool[5]),
                  1'b1, 1'b0, 1'b0, 1'b1);
        add_frame(make_frame(arp_pkg::ARP_OPER_REQUEST, mac_pool[9], ip_pool[7], local_ip),
                  1'b0, 1'b1, 1'b1, 1'b0);
        add_gap(8'd2);
        add_query(ip_pool[7]);
        add_query(ip_pool[6]);
        // Frame during the clear sweep, then everything misses
        add_clear(1'b1);
        add_frame(make_frame(arp_pkg::ARP_OPER_REQUEST, mac_pool[0], ip_pool[0], local_ip),
                  1'b0, 1'b1, 1'b1, 1'b0);
        add_gap(8'd2);
        for (int i = 0; i < 8; i++) begin
            add_query(ip_pool[i]);
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Step drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_MAX) stop_on_failure("Timeout: cache_busy never went low");
        end while (cache_busy !== 1'b0);
    endtask

    task automatic wait_learn_done();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_MAX) stop_on_failure("Timeout: learn_done never came for a frame");
            // Cache stays busy until the cycle that reports the learn
            check_value("cache_busy", 224'(learn_done !== 1'b1), 224'(cache_busy));
        end while (learn_done !== 1'b1);
    endtask

    // Reply is due exactly two cycles after the DUT samples the strobe
    task automatic run_frame(input step_t s);
        logic [15:0]       drops_before;
        arp_pkg::arp_hdr_t exp_hdr;
        exp_hdr = expected_reply(s.hdr);
        @(posedge clk);
        frame_valid <= 1'b1;
        frame       <= s.hdr;
        drops_before = drop_count;
        @(posedge clk);
        frame_valid <= 1'b0;
        check_value("reply_valid", 224'(1'b0), 224'(reply_valid));
        @(posedge clk);
        check_value("reply_valid", 224'(1'b0), 224'(reply_valid));
        @(posedge clk);
        check_value("reply_valid", 224'(s.exp_reply), 224'(reply_valid));
        if (s.exp_reply) begin
            check_value("reply_frame", exp_hdr, reply_frame);
        end
        check_value("drop_count", 224'(drops_before + 16'(s.exp_drop)), 224'(drop_count));
        if (s.exp_learn) begin
            model_learn(s.hdr.spa, s.hdr.sha);
            if (!s.no_wait) wait_learn_done();
        end
    endtask

    task automatic run_query(input logic [31:0] ip);
        int idx;
        int lat;
        idx = model_find(ip);
        @(posedge clk);
        query_valid <= 1'b1;
        query_ip    <= ip;
        @(posedge clk);
        query_valid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            if (lat > WAIT_MAX) stop_on_failure("Timeout: no response to a cache query");
        end while (query_resp_valid !== 1'b1);
        check_value("query latency", 224'(1), 224'(lat));
        check_value("query_resp.error", 224'(idx < 0), 224'(query_resp.error));
        if (idx >= 0) begin
            check_value("query_resp.mac", 224'(m_mac[idx]), 224'(query_resp.mac));
            model_touch(idx);
        end
    endtask

    task automatic run_clear(input logic no_wait);
        @(posedge clk);
        clear_cache <= 1'b1;
        @(posedge clk);
        clear_cache <= 1'b0;
        model_clear();
        if (!no_wait) wait_idle();
    endtask

    task automatic run_gap(input logic [7:0] cycles);
        repeat (cycles) @(posedge clk);
        wait_idle();
    endtask

    // Watchdog sized once the table is known
    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        stop_on_failure("Timeout: the test sequence did not finish in time");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        timeout_cycles = 0;
        lcg_state      = 32'hab88ab17;
        rst            = 1'b1;
        frame_valid    = 1'b0;
        frame          = '0;
        query_valid    = 1'b0;
        query_ip       = '0;
        clear_cache    = 1'b0;
        local_ip       = next_rand();
        local_mac      = rand_mac();
        for (int i = 0; i < 8; i++) begin
            ip_pool[i] = next_rand();
        end
        for (int i = 0; i < 10; i++) begin
            mac_pool[i] = rand_mac();
        end
        m_ptr = 0;
        model_clear();
        build_table();
        timeout_cycles = 64 + steps.size() * (WAIT_MAX + 8);

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        wait_idle();
        check_value("query_resp_valid", 224'(1'b0), 224'(query_resp_valid));
        check_value("reply_valid", 224'(1'b0), 224'(reply_valid));
        check_value("learn_done", 224'(1'b0), 224'(learn_done));
        check_value("drop_count", 224'(16'd0), 224'(drop_count));

        for (int i = 0; i < steps.size(); i++) begin
            case (steps[i].kind)
                STEP_FRAME: run_frame(steps[i]);
                STEP_QUERY: run_query(steps[i].ip);
                STEP_CLEAR: run_clear(steps[i].no_wait);
                default:    run_gap(steps[i].cycles);
            endcase
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
arp_pkg.sv
cache_pkg.sv
arp_decode.sv
arp_cache.sv
arp_reply.sv
arp_top.sv
tb_arp_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the log
rm -rf obj_dir build.log sim.log
verilator --binary -Wno-fatal --top-module tb_arp_top -f src.f -o tb_arp_top > build.log 2>&1 \
    && ./obj_dir/tb_arp_top > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
